// File: filelist.f
+incdir+logic
logic/bp_pkg.sv
logic/bp_btb.sv
logic/bp_pht.sv
logic/bp_ctrl.sv
logic/bp_top.sv
bench/bp_checker.sv
bench/bp_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= bp_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/bp_tb.sv
// Testbench for the branch predictor: clock, reset, directed and random stimulus, scoreboard
`timescale 1ns/1ps

module bp_tb;

    localparam int BTB_N  = bp_pkg::BTB_ENTRIES;
    localparam int PHT_N  = bp_pkg::PHT_ENTRIES;
    localparam int IDX_W  = bp_pkg::BTB_IDX_W;
    localparam int GHR_W  = bp_pkg::PHT_IDX_W;
    localparam int SWEEP_CYCLES = (BTB_N > PHT_N) ? BTB_N : PHT_N;

    // Counter walk outcomes, LSB first
    localparam logic [8:0] WALK_TAKEN = 9'b110000111;

    logic                clk;
    logic                rst_i;
    bp_pkg::addr_t       pc_i;
    logic                upd_valid_i;
    bp_pkg::bp_update_t  upd_i;
    logic                ghr_clear_i;
    bp_pkg::bp_pred_t    pred_o;
    logic                ready_o;

    // Scoreboard model of both tables and the history
    logic                m_valid  [BTB_N];
    bp_pkg::btb_tag_t    m_tag    [BTB_N];
    bp_pkg::addr_t       m_target [BTB_N];
    bp_pkg::br_kind_e    m_kind   [BTB_N];
    bp_pkg::ctr_t        m_ctr    [PHT_N];
    bp_pkg::pht_idx_t    m_ghr;
    logic                m_ready;

    integer              seed;
    int                  cycles;
    logic [31:0]         r1;
    logic [31:0]         r2;
    bp_pkg::addr_t       pc_r;
    bp_pkg::addr_t       pc_u;
    bp_pkg::opcode_t     op;
    bp_pkg::bp_update_t  upd;

    bp_top uut (
        .clk         (clk),
        .rst_i       (rst_i),
        .pc_i        (pc_i),
        .upd_valid_i (upd_valid_i),
        .upd_i       (upd_i),
        .ghr_clear_i (ghr_clear_i),
        .pred_o      (pred_o),
        .ready_o     (ready_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else abort_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    function automatic bp_pkg::bp_update_t make_upd(input bp_pkg::addr_t pc,
        input bp_pkg::addr_t target, input bp_pkg::opcode_t opc, input logic taken,
        input bp_pkg::pht_idx_t idx);
        bp_pkg::bp_update_t u;
        u.pc      = pc;
        u.target  = target;
        u.opcode  = opc;
        u.taken   = taken;
        u.pht_idx = idx;
        return u;
    endfunction

    // Expected prediction for the current pc_i
    task automatic check_pred();
        bp_pkg::btb_idx_t  idx;
        bp_pkg::pht_idx_t  gidx;
        logic              hit;
        logic              taken;
        bp_pkg::addr_t     target;
        idx    = pc_i[IDX_W+1:2];
        gidx   = pc_i[GHR_W+1:2] ^ m_ghr;
        hit    = m_ready && m_valid[idx] && (m_tag[idx] == pc_i[bp_pkg::XLEN-1:IDX_W+2]);
        taken  = hit && ((m_kind[idx] == bp_pkg::KIND_JUMP) ||
                 ((m_kind[idx] == bp_pkg::KIND_BRANCH) && m_ctr[gidx][1]));
        target = hit ? m_target[idx] : '0;
        check_value("ready_o", 32'(ready_o), 32'(m_ready));
        check_value("pred_o.hit", 32'(pred_o.hit), 32'(hit));
        check_value("pred_o.taken", 32'(pred_o.taken), 32'(taken));
        check_value("pred_o.target", pred_o.target, target);
        check_value("pred_o.pht_idx", 32'(pred_o.pht_idx), 32'(gidx));
    endtask

    // Table and history change at the coming clock edge
    task automatic model_edge();
        bp_pkg::btb_idx_t  idx;
        bp_pkg::br_kind_e  kind;
        idx  = upd_i.pc[IDX_W+1:2];
        kind = bp_pkg::KIND_NONE;
        if (upd_i.opcode == bp_pkg::OP_JAL || upd_i.opcode == bp_pkg::OP_JALR) begin
            kind = bp_pkg::KIND_JUMP;
        end else if (upd_i.opcode == bp_pkg::OP_BRANCH) begin
            kind = bp_pkg::KIND_BRANCH;
        end
        if (m_ready && upd_valid_i && kind != bp_pkg::KIND_NONE) begin
            m_valid[idx]  = 1'b1;
            m_tag[idx]    = upd_i.pc[bp_pkg::XLEN-1:IDX_W+2];
            m_target[idx] = upd_i.target;
            m_kind[idx]   = kind;
            if (kind == bp_pkg::KIND_BRANCH) begin
                if (upd_i.taken && m_ctr[upd_i.pht_idx] != 2'b11) begin
                    m_ctr[upd_i.pht_idx] = m_ctr[upd_i.pht_idx] + 2'd1;
                end else if (!upd_i.taken && m_ctr[upd_i.pht_idx] != 2'b00) begin
                    m_ctr[upd_i.pht_idx] = m_ctr[upd_i.pht_idx] - 2'd1;
                end
                m_ghr = {m_ghr[GHR_W-2:0], upd_i.taken};
            end
        end
        if (ghr_clear_i) begin
            m_ghr = '0;
        end
    endtask

    task automatic run_cycle(input bp_pkg::addr_t pc, input logic uv,
                             input bp_pkg::bp_update_t u, input logic clr);
        @(posedge clk);
        #1;
        pc_i        = pc;
        upd_valid_i = uv;
        upd_i       = u;
        ghr_clear_i = clr;
        @(negedge clk);
        check_pred();
        model_edge();
    endtask

    // Any concurrent assertion failure ends the run
    always @(negedge clk) begin
        if (uut.u_chk.fail_cnt != 0) begin
            abort_run("concurrent assertion failed in the checker");
        end
    end

    initial begin
        seed        = 81998;
        rst_i       = 1'b1;
        pc_i        = '0;
        upd_valid_i = 1'b0;
        upd_i       = '0;
        ghr_clear_i = 1'b0;
        m_ghr       = '0;
        m_ready     = 1'b0;
        for (int i = 0; i < BTB_N; i++) begin
            m_valid[i] = 1'b0;
        end
        for (int i = 0; i < PHT_N; i++) begin
            m_ctr[i] = 2'b01;
        end
        repeat (16) @(posedge clk);
        #1;
        rst_i = 1'b0;

        // Sweep: every lookup misses and an early JAL is dropped
        cycles = 0;
        while (!ready_o) begin
            cycles++;
            if (cycles > 4 * SWEEP_CYCLES) begin
                abort_run("timeout waiting for ready_o after reset");
            end
            m_ready = (cycles >= SWEEP_CYCLES);
            run_cycle(32'h0000_1004, cycles == 3,
                      make_upd(32'h0000_1004, 32'h0000_0abc, bp_pkg::OP_JAL, 1'b1, '0), 1'b0);
        end
        check_value("ready latency", 32'(cycles), 32'(SWEEP_CYCLES));

        // JAL hit from the next cycle, then a tag alias misses
        run_cycle(32'h0000_1004, 1'b1,
                  make_upd(32'h0000_1004, 32'h0000_2468, bp_pkg::OP_JAL, 1'b1, '0), 1'b0);
        run_cycle(32'h0000_1004, 1'b0, '0, 1'b0);
        run_cycle(32'h0000_1004 + (32'd1 << (IDX_W + 2)), 1'b0, '0, 1'b0);

        // Counter walk with history held clear: up three, down four, up two
        for (int i = 0; i < 9; i++) begin
            run_cycle(32'h0000_3010, 1'b1, make_upd(32'h0000_3010, 32'h0000_3100,
                      bp_pkg::OP_BRANCH, WALK_TAKEN[i], 5'h04), 1'b1);
        end
        run_cycle(32'h0000_3010, 1'b0, '0, 1'b1);

        // History shift moves the index, clear restores the PC bits
        run_cycle(32'h0000_5020, 1'b1, make_upd(32'h0000_5020, 32'h0000_5800,
                  bp_pkg::OP_BRANCH, 1'b1, 5'h08), 1'b0);
        run_cycle(32'h0000_5020, 1'b0, '0, 1'b0);
        check_value("pht_idx after shift", 32'(pred_o.pht_idx), 32'h09);
        run_cycle(32'h0000_5020, 1'b1, make_upd(32'h0000_5020, 32'h0000_5800,
                  bp_pkg::OP_BRANCH, 1'b1, 5'h09), 1'b1);
        run_cycle(32'h0000_5020, 1'b0, '0, 1'b0);
        check_value("pht_idx after clear", 32'(pred_o.pht_idx), 32'h08);

        // JALR replaces a branch entry and is then always taken
        run_cycle(32'h0000_6040, 1'b1, make_upd(32'h0000_6040, 32'h0000_6400,
                  bp_pkg::OP_BRANCH, 1'b0, 5'h10), 1'b0);
        run_cycle(32'h0000_6040, 1'b1, make_upd(32'h0000_6040, 32'h0000_7000,
                  bp_pkg::OP_JALR, 1'b0, '0), 1'b0);
        for (int i = 0; i < 4; i++) begin
            run_cycle(32'h0000_6040, 1'b1, make_upd(32'h0000_8008, 32'h0000_8800,
                      bp_pkg::OP_BRANCH, i[0], 5'h02), 1'b0);
            check_value("jalr entry taken", 32'(pred_o.taken), 32'h1);
        end

        // Random mix over a small PC pool so entries get reused
        for (int n = 0; n < 300; n++) begin
            r1   = $random(seed);
            r2   = $random(seed);
            pc_r = 32'h0001_0000 + (32'(r1[8:7]) << (IDX_W + 2)) + (32'(r1[3:0]) << 2);
            pc_u = 32'h0001_0000 + (32'(r2[8:7]) << (IDX_W + 2)) + (32'(r2[3:0]) << 2);
            case (r2[11:10])
                2'd0: op = bp_pkg::OP_JAL;
                2'd1: op = bp_pkg::OP_JALR;
                default: op = bp_pkg::OP_BRANCH;
            endcase
            if (r2[14:12] == 3'd0) begin
                op = 7'h13;
            end
            upd = make_upd(pc_u, {r1[31:10], 10'h100}, op, r2[15], pc_u[GHR_W+1:2] ^ m_ghr);
            run_cycle(pc_r, r2[16] | r2[17], upd, r2[21:18] == 4'd0);
        end

        @(posedge clk);
        #1;
        upd_valid_i = 1'b0;
        ghr_clear_i = 1'b0;
        if (uut.u_chk.fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run("concurrent assertion failed in the checker");
        end
    end

endmodule

// File: bench/bp_checker.sv
// Concurrent assertions on the predictor top level, with a shadow history register
`timescale 1ns/1ps

module bp_checker (
    input logic                clk,
    input logic                rst_i,
    input bp_pkg::addr_t       pc_i,
    input logic                upd_valid_i,
    input bp_pkg::bp_update_t  upd_i,
    input logic                ghr_clear_i,
    input bp_pkg::bp_pred_t    pred_i,
    input logic                ready_i
);

    // Failure count, read by the testbench
    int                fail_cnt = 0;
    bp_pkg::pht_idx_t  ghr_shadow;

    // Shift only resolved branches once the sweep is over, clear wins
    always_ff @(posedge clk) begin
        if (rst_i || ghr_clear_i) begin
            ghr_shadow <= '0;
        end else if (ready_i && upd_valid_i && (upd_i.opcode == bp_pkg::OP_BRANCH)) begin
            ghr_shadow <= {ghr_shadow[bp_pkg::PHT_IDX_W-2:0], upd_i.taken};
        end
    end

    a_ready_low_in_reset: assert property (@(posedge clk) rst_i && $past(rst_i) |-> !ready_i)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("ready_o is high while reset is asserted");
    end

    a_no_hit_before_ready: assert property (@(posedge clk) !ready_i |-> !pred_i.hit)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("prediction hit while ready_o is low");
    end

    a_gshare_index: assert property (@(posedge clk) disable iff (rst_i)
        pred_i.pht_idx == (pc_i[bp_pkg::PHT_IDX_W+1:2] ^ ghr_shadow))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("pht_idx differs from PC bits xor shadow history");
    end

    a_taken_target_nonzero: assert property (@(posedge clk) disable iff (rst_i)
        !(pred_i.hit && pred_i.taken && (pred_i.target == '0)))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("taken hit predicted with a zero target");
    end

endmodule

bind bp_top bp_checker u_chk (
    .clk         (clk),
    .rst_i       (rst_i),
    .pc_i        (pc_i),
    .upd_valid_i (upd_valid_i),
    .upd_i       (upd_i),
    .ghr_clear_i (ghr_clear_i),
    .pred_i      (pred_o),
    .ready_i     (ready_o)
);

// File: logic/bp_top.sv
// Branch prediction unit top level: control, target buffer and counter table
`timescale 1ns/1ps

module bp_top (
    input  logic                clk,
    input  logic                rst_i,

    input  bp_pkg::addr_t       pc_i,
    input  logic                upd_valid_i,
    input  bp_pkg::bp_update_t  upd_i,
    input  logic                ghr_clear_i,

    output bp_pkg::bp_pred_t    pred_o,
    output logic                ready_o
);

    logic                btb_hit;
    bp_pkg::br_kind_e    btb_kind;
    bp_pkg::addr_t       btb_target;
    logic                btb_wr_en;
    bp_pkg::addr_t       btb_wr_pc;
    bp_pkg::addr_t       btb_wr_target;
    bp_pkg::br_kind_e    btb_wr_kind;
    logic                btb_wr_valid;

    bp_pkg::ctr_t        pht_ctr;
    bp_pkg::pht_idx_t    pht_rd_idx;
    logic                pht_wr_en;
    bp_pkg::pht_idx_t    pht_wr_idx;
    bp_pkg::pht_cmd_t    pht_wr_cmd;

    bp_ctrl u_ctrl (
        .clk             (clk),
        .rst_i           (rst_i),
        .pc_i            (pc_i),
        .upd_valid_i     (upd_valid_i),
        .upd_i           (upd_i),
        .ghr_clear_i     (ghr_clear_i),
        .btb_hit_i       (btb_hit),
        .btb_kind_i      (btb_kind),
        .btb_target_i    (btb_target),
        .btb_wr_en_o     (btb_wr_en),
        .btb_wr_pc_o     (btb_wr_pc),
        .btb_wr_target_o (btb_wr_target),
        .btb_wr_kind_o   (btb_wr_kind),
        .btb_wr_valid_o  (btb_wr_valid),
        .pht_ctr_i       (pht_ctr),
        .pht_rd_idx_o    (pht_rd_idx),
        .pht_wr_en_o     (pht_wr_en),
        .pht_wr_idx_o    (pht_wr_idx),
        .pht_wr_cmd_o    (pht_wr_cmd),
        .pred_o          (pred_o),
        .ready_o         (ready_o)
    );

    bp_btb u_btb (
        .clk         (clk),
        .rst_i       (rst_i),
        .rd_pc_i     (pc_i),
        .hit_o       (btb_hit),
        .kind_o      (btb_kind),
        .target_o    (btb_target),
        .wr_en_i     (btb_wr_en),
        .wr_pc_i     (btb_wr_pc),
        .wr_target_i (btb_wr_target),
        .wr_kind_i   (btb_wr_kind),
        .wr_valid_i  (btb_wr_valid)
    );

    bp_pht u_pht (
        .clk      (clk),
        .rd_idx_i (pht_rd_idx),
        .ctr_o    (pht_ctr),
        .wr_en_i  (pht_wr_en),
        .wr_idx_i (pht_wr_idx),
        .wr_cmd_i (pht_wr_cmd)
    );

endmodule

// File: logic/bp_ctrl.sv
// Predictor control: clear sweep FSM, global history, gshare index, update steering, decision
`timescale 1ns/1ps

module bp_ctrl (
    input  logic                clk,
    input  logic                rst_i,

    input  bp_pkg::addr_t       pc_i,
    input  logic                upd_valid_i,
    input  bp_pkg::bp_update_t  upd_i,
    input  logic                ghr_clear_i,

    // BTB lookup result
    input  logic                btb_hit_i,
    input  bp_pkg::br_kind_e    btb_kind_i,
    input  bp_pkg::addr_t       btb_target_i,

    // BTB write
    output logic                btb_wr_en_o,
    output bp_pkg::addr_t       btb_wr_pc_o,
    output bp_pkg::addr_t       btb_wr_target_o,
    output bp_pkg::br_kind_e    btb_wr_kind_o,
    output logic                btb_wr_valid_o,

    // PHT lookup and write
    input  bp_pkg::ctr_t        pht_ctr_i,
    output bp_pkg::pht_idx_t    pht_rd_idx_o,
    output logic                pht_wr_en_o,
    output bp_pkg::pht_idx_t    pht_wr_idx_o,
    output bp_pkg::pht_cmd_t    pht_wr_cmd_o,

    output bp_pkg::bp_pred_t    pred_o,
    output logic                ready_o
);

    bp_pkg::ctrl_state_e  state_q;
    bp_pkg::sweep_cnt_t   sweep_cnt_q;
    bp_pkg::pht_idx_t     ghr_q;

    bp_pkg::pht_idx_t     gshare_idx;
    bp_pkg::br_kind_e     upd_kind;
    bp_pkg::addr_t        sweep_pc;
    logic                 running;
    logic                 clearing;
    logic                 upd_go;
    logic                 upd_branch;
    logic                 pred_hit;

    assign running  = (state_q == bp_pkg::ST_RUN);
    assign clearing = (state_q == bp_pkg::ST_CLEAR);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q     <= bp_pkg::ST_CLEAR;
            sweep_cnt_q <= '0;
        end else if (clearing) begin
            sweep_cnt_q <= sweep_cnt_q + 1'b1;
            if (sweep_cnt_q == bp_pkg::SWEEP_LAST) begin
                state_q <= bp_pkg::ST_RUN;
            end
        end
    end

    // Resolved opcode to entry kind
    always_comb begin
        case (upd_i.opcode)
            bp_pkg::OP_JAL, bp_pkg::OP_JALR: upd_kind = bp_pkg::KIND_JUMP;
            bp_pkg::OP_BRANCH:               upd_kind = bp_pkg::KIND_BRANCH;
            default:                         upd_kind = bp_pkg::KIND_NONE;
        endcase
    end

    assign upd_go     = running && upd_valid_i && (upd_kind != bp_pkg::KIND_NONE);
    assign upd_branch = upd_go && (upd_kind == bp_pkg::KIND_BRANCH);

    // History clear wins over a shift in the same cycle
    always_ff @(posedge clk) begin
        if (rst_i || ghr_clear_i) begin
            ghr_q <= '0;
        end else if (upd_branch) begin
            ghr_q <= {ghr_q[bp_pkg::PHT_IDX_W-2:0], upd_i.taken};
        end
    end

    assign gshare_idx = pc_i[bp_pkg::PHT_IDX_W+1:2] ^ ghr_q;

    always_comb begin
        sweep_pc = '0;
        sweep_pc[bp_pkg::BTB_IDX_W+1:2] = sweep_cnt_q[bp_pkg::BTB_IDX_W-1:0];
    end

    // Sweep owns both write ports until the tables are clear
    assign btb_wr_en_o     = clearing || upd_go;
    assign btb_wr_pc_o     = clearing ? sweep_pc : upd_i.pc;
    assign btb_wr_target_o = clearing ? '0 : upd_i.target;
    assign btb_wr_kind_o   = clearing ? bp_pkg::KIND_NONE : upd_kind;
    assign btb_wr_valid_o  = !clearing;

    assign pht_rd_idx_o = gshare_idx;
    assign pht_wr_en_o  = clearing || upd_branch;
    assign pht_wr_idx_o = clearing ? sweep_cnt_q[bp_pkg::PHT_IDX_W-1:0] : upd_i.pht_idx;

    always_comb begin
        if (clearing) begin
            pht_wr_cmd_o = bp_pkg::PHT_CMD_CLR;
        end else if (upd_branch) begin
            pht_wr_cmd_o = upd_i.taken ? bp_pkg::PHT_CMD_INC : bp_pkg::PHT_CMD_DEC;
        end else begin
            pht_wr_cmd_o = bp_pkg::PHT_CMD_HOLD;
        end
    end

    // Jumps always taken, branches follow the counter MSB
    assign pred_hit = running && btb_hit_i;

    assign pred_o.hit     = pred_hit;
    assign pred_o.taken   = pred_hit && ((btb_kind_i == bp_pkg::KIND_JUMP) ||
                            ((btb_kind_i == bp_pkg::KIND_BRANCH) && pht_ctr_i[1]));
    assign pred_o.target  = pred_hit ? btb_target_i : '0;
    assign pred_o.pht_idx = gshare_idx;

    assign ready_o = running;

endmodule

// File: logic/bp_pht.sv
// Gshare pattern history table of 2-bit saturating counters
`timescale 1ns/1ps

module bp_pht (
    input  logic               clk,

    // Combinational lookup
    input  bp_pkg::pht_idx_t   rd_idx_i,
    output bp_pkg::ctr_t       ctr_o,

    // Training and clear writes
    input  logic               wr_en_i,
    input  bp_pkg::pht_idx_t   wr_idx_i,
    input  bp_pkg::pht_cmd_t   wr_cmd_i
);

    bp_pkg::ctr_t ctr_q [bp_pkg::PHT_ENTRIES];

    bp_pkg::ctr_t cur_ctr;
    bp_pkg::ctr_t nxt_ctr;

    assign ctr_o   = ctr_q[rd_idx_i];
    assign cur_ctr = ctr_q[wr_idx_i];

    // Next counter value for the selected command
    always_comb begin
        nxt_ctr = cur_ctr;
        case (wr_cmd_i)
            bp_pkg::PHT_CMD_INC: begin
                if (cur_ctr != 2'b11) begin
                    nxt_ctr = cur_ctr + 2'd1;
                end
            end
            bp_pkg::PHT_CMD_DEC: begin
                if (cur_ctr != 2'b00) begin
                    nxt_ctr = cur_ctr - 2'd1;
                end
            end
            // Weakly not taken
            bp_pkg::PHT_CMD_CLR: begin
                nxt_ctr = 2'b01;
            end
            default: begin
                nxt_ctr = cur_ctr;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            ctr_q[wr_idx_i] <= nxt_ctr;
        end
    end

endmodule

// File: logic/bp_btb.sv
// Direct-mapped branch target buffer with one lookup port and one write port
`timescale 1ns/1ps

module bp_btb (
    input  logic               clk,
    input  logic               rst_i,

    // Lookup from fetch
    input  bp_pkg::addr_t      rd_pc_i,
    output logic               hit_o,
    output bp_pkg::br_kind_e   kind_o,
    output bp_pkg::addr_t      target_o,

    // Update or clear write
    input  logic               wr_en_i,
    input  bp_pkg::addr_t      wr_pc_i,
    input  bp_pkg::addr_t      wr_target_i,
    input  bp_pkg::br_kind_e   wr_kind_i,
    input  logic               wr_valid_i
);

    // Entry storage, cleared by the sweep in control
    bp_pkg::btb_tag_t  tag_q    [bp_pkg::BTB_ENTRIES];
    bp_pkg::addr_t     target_q [bp_pkg::BTB_ENTRIES];
    bp_pkg::br_kind_e  kind_q   [bp_pkg::BTB_ENTRIES];
    logic              valid_q  [bp_pkg::BTB_ENTRIES];

    bp_pkg::btb_idx_t  rd_idx;
    bp_pkg::btb_tag_t  rd_tag;
    bp_pkg::btb_idx_t  wr_idx;
    bp_pkg::btb_tag_t  wr_tag;
    logic              tag_eq;

    // Index sits just above the halfword bits, tag takes the rest
    assign rd_idx = rd_pc_i[bp_pkg::BTB_IDX_W+1:2];
    assign rd_tag = rd_pc_i[bp_pkg::XLEN-1:bp_pkg::BTB_IDX_W+2];
    assign wr_idx = wr_pc_i[bp_pkg::BTB_IDX_W+1:2];
    assign wr_tag = wr_pc_i[bp_pkg::XLEN-1:bp_pkg::BTB_IDX_W+2];

    assign tag_eq = (tag_q[rd_idx] == rd_tag);

    assign hit_o    = valid_q[rd_idx] && tag_eq;
    assign kind_o   = kind_q[rd_idx];
    assign target_o = target_q[rd_idx];

    // Whole entry is replaced on every write
    // Writes are held off while reset is asserted
    always_ff @(posedge clk) begin
        if (wr_en_i && !rst_i) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= wr_target_i;
            kind_q[wr_idx]   <= wr_kind_i;
            valid_q[wr_idx]  <= wr_valid_i;
        end
    end

endmodule

// File: logic/bp_pkg.sv
// Predictor types, kind and state enums, opcode and command constants, prediction structs
package bp_pkg;

`include "bp_cfg.svh"

    localparam int XLEN        = `BP_XLEN;
    localparam int BTB_ENTRIES = `BP_BTB_ENTRIES;
    localparam int BTB_IDX_W   = $clog2(`BP_BTB_ENTRIES);
    localparam int BTB_TAG_W   = `BP_XLEN - BTB_IDX_W - 2;
    localparam int PHT_ENTRIES = `BP_PHT_ENTRIES;
    localparam int PHT_IDX_W   = `BP_GHR_BITS;

    // Sweep covers the deeper of the two tables
    localparam int SWEEP_DEPTH = (BTB_ENTRIES > PHT_ENTRIES) ? BTB_ENTRIES : PHT_ENTRIES;
    localparam int SWEEP_W     = $clog2(SWEEP_DEPTH);

    typedef logic [XLEN-1:0]      addr_t;
    typedef logic [BTB_IDX_W-1:0] btb_idx_t;
    typedef logic [BTB_TAG_W-1:0] btb_tag_t;
    typedef logic [PHT_IDX_W-1:0] pht_idx_t;
    typedef logic [1:0]           ctr_t;
    typedef logic [6:0]           opcode_t;
    typedef logic [1:0]           pht_cmd_t;
    typedef logic [SWEEP_W-1:0]   sweep_cnt_t;

    localparam sweep_cnt_t SWEEP_LAST = sweep_cnt_t'(SWEEP_DEPTH - 1);

    typedef enum logic [1:0] {
        KIND_NONE,
        KIND_JUMP,
        KIND_BRANCH
    } br_kind_e;

    typedef enum logic {
        ST_CLEAR,
        ST_RUN
    } ctrl_state_e;

    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;

    // Counter write commands
    localparam pht_cmd_t PHT_CMD_HOLD = 2'b00;
    localparam pht_cmd_t PHT_CMD_INC  = 2'b01;
    localparam pht_cmd_t PHT_CMD_DEC  = 2'b10;
    localparam pht_cmd_t PHT_CMD_CLR  = 2'b11;

    typedef struct packed {
        logic     hit;
        logic     taken;
        addr_t    target;
        pht_idx_t pht_idx;
    } bp_pred_t;

    typedef struct packed {
        addr_t    pc;
        addr_t    target;
        opcode_t  opcode;
        logic     taken;
        pht_idx_t pht_idx;
    } bp_update_t;

endpackage

// File: logic/bp_cfg.svh
// Size and width macros for the branch predictor tables
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// Address width of PCs and targets
`define BP_XLEN 32

// Direct-mapped BTB depth, power of two
`define BP_BTB_ENTRIES 32

// Global history length
// Also sets the gshare table depth
`define BP_GHR_BITS 5

// One counter per history pattern
`define BP_PHT_ENTRIES (1 << `BP_GHR_BITS)

`endif
